// File: design/baudTimer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit period timer for the UART
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module baudTimer #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic bitTick
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CNT_W-1:0] count;

    // Held at the reload value while stopped so each rise of run starts a full period
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(CLKS_PER_BIT - 1);
        end else if (!run || bitTick) begin
            count <= CNT_W'(CLKS_PER_BIT - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    assign bitTick = run && (count == '0);

    // No tick while stopped or on the cycle that run rises
    tickOnlyWhileRunning: assert property (
        @(posedge clk) disable iff (reset)
        bitTick |-> run && ($past(run) || CLKS_PER_BIT == 1)
    );

endmodule

`default_nettype wire

// File: design/ioSubsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O subsystem top level
// I/O unit, serial FIFO, baud timer, UART
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ioSubsystem
    import ioTypes::*;
#(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  IoWriteReq  writeReq,
    input  PhyAddrPath readAddr,
    output DataPath    readData,
    output logic       timerIrq,
    output logic       txd
);

    logic      serialWe;
    SerialByte serialData;
    logic      fifoFull;
    logic      fifoEmpty;
    logic      pop;
    SerialByte headByte;
    logic      run;
    logic      bitTick;
    logic      uartBusy;
    logic      txBusy;

    // Busy until the line is idle and nothing is queued
    assign txBusy = uartBusy || !fifoEmpty;

    ioUnit ioUnitInst (
        .clk        (clk),
        .reset      (reset),
        .writeReq   (writeReq),
        .readAddr   (readAddr),
        .readData   (readData),
        .timerIrq   (timerIrq),
        .serialWe   (serialWe),
        .serialData (serialData),
        .fifoFull   (fifoFull),
        .fifoEmpty  (fifoEmpty),
        .txBusy     (txBusy)
    );

    serialFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) serialFifoInst (
        .clk      (clk),
        .reset    (reset),
        .push     (serialWe),
        .pushByte (serialData),
        .pop      (pop),
        .headByte (headByte),
        .full     (fifoFull),
        .empty    (fifoEmpty)
    );

    baudTimer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) baudTimerInst (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .bitTick (bitTick)
    );

    uartTx uartTxInst (
        .clk       (clk),
        .reset     (reset),
        .fifoEmpty (fifoEmpty),
        .headByte  (headByte),
        .pop       (pop),
        .run       (run),
        .bitTick   (bitTick),
        .txd       (txd),
        .busy      (uartBusy)
    );

endmodule

`default_nettype wire

// File: design/ioTypes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the I/O subsystem
// Word types, timer structs, write request
// Address map, register and UART enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ioTypes;

    typedef logic [31:0] DataPath;
    typedef logic [15:0] PhyAddrPath;
    typedef logic [7:0]  SerialByte;

    // 64-bit timer value, hi half in the upper bits
    typedef struct packed {
        DataPath hi;
        DataPath low;
    } TimerValue;

    typedef struct packed {
        TimerValue mtime;
        TimerValue mtimecmp;
    } TimerRegs;

    typedef struct packed {
        PhyAddrPath addr;
        DataPath    data;
        logic       we;
    } IoWriteReq;

    localparam PhyAddrPath PHY_ADDR_TIMER_LOW     = 16'h0000;
    localparam PhyAddrPath PHY_ADDR_TIMER_HI      = 16'h0004;
    localparam PhyAddrPath PHY_ADDR_TIMER_CMP_LOW = 16'h0008;
    localparam PhyAddrPath PHY_ADDR_TIMER_CMP_HI  = 16'h000C;
    localparam PhyAddrPath PHY_ADDR_SERIAL_OUTPUT = 16'h0010;
    localparam PhyAddrPath PHY_ADDR_SERIAL_STATUS = 16'h0014;

    // Bit positions in the serial status word
    localparam int SERIAL_STATUS_FULL_BIT = 0;
    localparam int SERIAL_STATUS_BUSY_BIT = 1;

    typedef enum logic [2:0] {
        REG_TIMER_LOW,
        REG_TIMER_HI,
        REG_CMP_LOW,
        REG_CMP_HI,
        REG_SERIAL_OUT,
        REG_SERIAL_STATUS,
        REG_NONE
    } IoRegSel;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } UartState;

    function automatic IoRegSel decodeAddr(input PhyAddrPath addr);
        IoRegSel sel;
        case (addr)
            PHY_ADDR_TIMER_LOW:     sel = REG_TIMER_LOW;
            PHY_ADDR_TIMER_HI:      sel = REG_TIMER_HI;
            PHY_ADDR_TIMER_CMP_LOW: sel = REG_CMP_LOW;
            PHY_ADDR_TIMER_CMP_HI:  sel = REG_CMP_HI;
            PHY_ADDR_SERIAL_OUTPUT: sel = REG_SERIAL_OUT;
            PHY_ADDR_SERIAL_STATUS: sel = REG_SERIAL_STATUS;
            default:                sel = REG_NONE;
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

// File: design/ioUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O unit with address decode, machine
// timer, interrupt compare, read mux and
// serial output strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ioUnit
    import ioTypes::*;
(
    input  logic       clk,
    input  logic       reset,
    input  IoWriteReq  writeReq,
    input  PhyAddrPath readAddr,
    output DataPath    readData,
    output logic       timerIrq,
    output logic       serialWe,
    output SerialByte  serialData,
    input  logic       fifoFull,
    input  logic       fifoEmpty,
    input  logic       txBusy
);

    TimerRegs tmReg;
    TimerRegs tmNext;
    IoRegSel  writeSel;
    IoRegSel  readSel;
    logic     statusBusy;
    DataPath  statusWord;

    always_ff @(posedge clk) begin
        if (reset) begin
            tmReg <= '0;
        end else begin
            tmReg <= tmNext;
        end
    end

    assign writeSel = decodeAddr(writeReq.addr);
    assign readSel  = decodeAddr(readAddr);

    // Increment first and let a written half override
    always_comb begin
        tmNext = tmReg;
        tmNext.mtime = 64'(tmReg.mtime) + 64'd1;
        if (writeReq.we) begin
            case (writeSel)
                REG_TIMER_LOW: tmNext.mtime.low    = writeReq.data;
                REG_TIMER_HI:  tmNext.mtime.hi     = writeReq.data;
                REG_CMP_LOW:   tmNext.mtimecmp.low = writeReq.data;
                REG_CMP_HI:    tmNext.mtimecmp.hi  = writeReq.data;
                default: ;
            endcase
        end
    end

    // Interrupt level looks at the values after this edge
    assign timerIrq = 64'(tmNext.mtime) >= 64'(tmNext.mtimecmp);

    // A queued byte still counts as busy
    assign statusBusy = txBusy || !fifoEmpty;

    always_comb begin
        statusWord = '0;
        statusWord[SERIAL_STATUS_FULL_BIT] = fifoFull;
        statusWord[SERIAL_STATUS_BUSY_BIT] = statusBusy;
    end

    // Zero-latency read path from the current registers
    always_comb begin
        case (readSel)
            REG_TIMER_LOW:     readData = tmReg.mtime.low;
            REG_TIMER_HI:      readData = tmReg.mtime.hi;
            REG_CMP_LOW:       readData = tmReg.mtimecmp.low;
            REG_SERIAL_STATUS: readData = statusWord;
            // Unmapped addresses fall back to mtimecmp hi
            default:           readData = tmReg.mtimecmp.hi;
        endcase
    end

    // Serial strobe and low byte of the write data
    assign serialWe   = writeReq.we && (writeSel == REG_SERIAL_OUT);
    assign serialData = writeReq.data[$bits(SerialByte)-1:0];

    // A serial strobe only comes with a core write to the serial-output address
    serialNeedsWrite: assert property (
        @(posedge clk) disable iff (reset)
        serialWe |-> writeReq.we && (writeReq.addr == PHY_ADDR_SERIAL_OUTPUT)
    );

endmodule

`default_nettype wire

// File: design/serialFifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte FIFO between I/O unit and UART
// Circular buffer with occupancy count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module serialFifo
    import ioTypes::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      push,
    input  SerialByte pushByte,
    input  logic      pop,
    output SerialByte headByte,
    output logic      full,
    output logic      empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    SerialByte        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doPush;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign headByte = mem[rdPtr];

    // Bytes arriving while full are dropped
    assign doPush = push && !full;

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushByte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(doPush) - CNT_W'(pop);
        end
    end

    // Transmitter only takes a byte that is there
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    );

endmodule

`default_nettype wire

// File: design/uartTx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 serial transmitter FSM
// Shift register and bit counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uartTx
    import ioTypes::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fifoEmpty,
    input  SerialByte headByte,
    output logic      pop,
    output logic      run,
    input  logic      bitTick,
    output logic      txd,
    output logic      busy
);

    UartState  state;
    UartState  stateNext;
    SerialByte shiftReg;
    SerialByte shiftNext;
    logic [2:0] bitCnt;
    logic [2:0] bitCntNext;
    logic       txdNext;

    assign pop  = (state == TX_IDLE) && !fifoEmpty;
    assign run  = (state != TX_IDLE);
    assign busy = (state != TX_IDLE);

    always_comb begin
        stateNext  = state;
        shiftNext  = shiftReg;
        bitCntNext = bitCnt;
        case (state)
            TX_IDLE: begin
                if (pop) begin
                    shiftNext = headByte;
                    stateNext = TX_START;
                end
            end
            TX_START: begin
                if (bitTick) begin
                    bitCntNext = '0;
                    stateNext  = TX_DATA;
                end
            end
            TX_DATA: begin
                if (bitTick) begin
                    // LSB first
                    shiftNext  = shiftReg >> 1;
                    bitCntNext = bitCnt + 1'b1;
                    if (bitCnt == 3'd7) begin
                        stateNext = TX_STOP;
                    end
                end
            end
            default: begin
                if (bitTick) begin
                    stateNext = TX_IDLE;
                end
            end
        endcase
    end

    // Line level for the state being entered
    always_comb begin
        case (stateNext)
            TX_START: txdNext = 1'b0;
            TX_DATA:  txdNext = shiftNext[0];
            default:  txdNext = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TX_IDLE;
            txd   <= 1'b1;
        end else begin
            state <= stateNext;
            txd   <= txdNext;
        end
    end

    always_ff @(posedge clk) begin
        shiftReg <= shiftNext;
        bitCnt   <= bitCntNext;
    end

    // Registered line stays at mark level while idle
    idleLineHigh: assert property (
        @(posedge clk) disable iff (reset)
        (state == TX_IDLE) |-> txd
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Compile the I/O subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f vlog.f \
    --top-module ioSubsystemTb

./obj_dir/VioSubsystemTb

// File: tb/ioSubsystemTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the I/O subsystem
// Timer, compare and serial output tests
// Reference models, LFSR, txd decoder, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ioSubsystemTb
    import ioTypes::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int CLKS_PER_BIT   = 4;
    localparam int FIFO_DEPTH     = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int SERIAL_COUNT   = 4;
    localparam int BURST_COUNT    = 10;
    localparam int IRQ_LEAD       = 24;
    localparam int BIT_TIME       = CLKS_PER_BIT * CLK_PERIOD;
    // One unit before a clock edge near the middle of a bit
    localparam int HALF_BIT       = BIT_TIME / 2 - 1;
    localparam int TIMEOUT_CYCLES = (SERIAL_COUNT + BURST_COUNT) * 10 * CLKS_PER_BIT + 2000;

    logic       clk;
    logic       reset;
    IoWriteReq  writeReq;
    PhyAddrPath readAddr;
    DataPath    readData;
    logic       timerIrq;
    logic       txd;

    logic [15:0] lfsrState = 16'd11;
    logic [63:0] mtimeModel;
    logic [63:0] cmpModel;
    SerialByte   expectQueue[$];
    SerialByte   rxQueue[$];
    string       testName;

    ioSubsystem #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .writeReq (writeReq),
        .readAddr (readAddr),
        .readData (readData),
        .timerIrq (timerIrq),
        .txd      (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic DataPath randomBits(input int count);
        DataPath r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] mtimeAfter(input logic [63:0] start, input int cycles);
        return start + 64'(cycles);
    endfunction

    // Register value after the coming edge
    function automatic logic [63:0] nextMtime(input logic [63:0] cur, input IoWriteReq req);
        logic [63:0] n;
        n = cur + 64'd1;
        if (req.we && req.addr == PHY_ADDR_TIMER_LOW) begin
            n[31:0] = req.data;
        end else if (req.we && req.addr == PHY_ADDR_TIMER_HI) begin
            n[63:32] = req.data;
        end
        return n;
    endfunction

    function automatic logic [63:0] nextCmp(input logic [63:0] cur, input IoWriteReq req);
        logic [63:0] n;
        n = cur;
        if (req.we && req.addr == PHY_ADDR_TIMER_CMP_LOW) begin
            n[31:0] = req.data;
        end else if (req.we && req.addr == PHY_ADDR_TIMER_CMP_HI) begin
            n[63:32] = req.data;
        end
        return n;
    endfunction

    function automatic logic irqExpected(input logic [63:0] mt, input logic [63:0] cmp);
        return mt >= cmp;
    endfunction

    function automatic logic fifoAccepts(input DataPath status);
        return !status[SERIAL_STATUS_FULL_BIT];
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input DataPath expected, input DataPath actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkIrq(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic checkByte(input string name, input SerialByte expected,
                             input SerialByte actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Drive point one unit after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Sample point one unit before the next edge
    task automatic sampleWait();
        #(CLK_PERIOD - 2);
    endtask

    task automatic writeWord(input PhyAddrPath addr, input DataPath data);
        writeReq.addr = addr;
        writeReq.data = data;
        writeReq.we   = 1'b1;
        nextCycle();
        writeReq.we   = 1'b0;
    endtask

    task automatic waitSerialIdle();
        readAddr = PHY_ADDR_SERIAL_STATUS;
        sampleWait();
        while (readData[SERIAL_STATUS_BUSY_BIT]) begin
            nextCycle();
            sampleWait();
        end
        nextCycle();
    endtask

    task automatic checkAllReceived();
        repeat (2) nextCycle();
        if (expectQueue.size() != 0) begin
            abortRun($sformatf("%s: %0d expected bytes never appeared on txd",
                               testName, expectQueue.size()));
        end
    endtask

    // Timer model follows the inputs seen at each edge
    always @(posedge clk) begin
        if (reset) begin
            mtimeModel <= '0;
            cmpModel   <= '0;
        end else begin
            mtimeModel <= nextMtime(mtimeModel, writeReq);
            cmpModel   <= nextCmp(cmpModel, writeReq);
        end
    end

    // Interrupt level checked every cycle
    initial begin
        forever begin
            @(posedge clk);
            #(CLK_PERIOD - 1);
            if (!reset) begin
                checkIrq("timer interrupt",
                         irqExpected(nextMtime(mtimeModel, writeReq),
                                     nextCmp(cmpModel, writeReq)),
                         timerIrq);
            end
        end
    end

    // 8N1 serial line decoder
    initial begin
        SerialByte rx;
        @(negedge reset);
        forever begin
            @(negedge txd);
            #HALF_BIT;
            if (txd !== 1'b0) begin
                abortRun("framing error: start bit did not stay low");
            end
            for (int i = 0; i < 8; i++) begin
                #BIT_TIME;
                rx[i] = txd;
            end
            #BIT_TIME;
            if (txd !== 1'b1) begin
                abortRun("framing error: stop bit was not high");
            end
            rxQueue.push_back(rx);
        end
    end

    // Received bytes against the expected order
    initial begin
        SerialByte got;
        SerialByte exp;
        forever begin
            @(posedge clk);
            while (rxQueue.size() > 0) begin
                got = rxQueue.pop_front();
                if (expectQueue.size() == 0) begin
                    abortRun($sformatf("unexpected byte %h on txd", got));
                end
                exp = expectQueue.pop_front();
                checkByte(testName, exp, got);
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abortRun("watchdog timeout: tests did not finish in time");
    end

    initial begin
        DataPath     word;
        DataPath     hiWord;
        logic [63:0] timerVal;
        logic [63:0] target;
        logic        sawLow;
        logic        sawHigh;
        int          accepted;

        reset    = 1'b1;
        writeReq = '0;
        readAddr = '0;
        testName = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        testName = "timer count";
        word = randomBits(32);
        readAddr = PHY_ADDR_TIMER_LOW;
        writeWord(PHY_ADDR_TIMER_LOW, word);
        for (int k = 0; k < 6; k++) begin
            sampleWait();
            timerVal = mtimeAfter({32'h0, word}, k);
            checkWord(testName, timerVal[31:0], readData);
            nextCycle();
        end

        testName = "timer carry";
        writeWord(PHY_ADDR_TIMER_LOW, 32'hFFFF_FFFE);
        hiWord = randomBits(32);
        writeWord(PHY_ADDR_TIMER_HI, hiWord);
        // Low half has counted up to all ones at this edge
        readAddr = PHY_ADDR_TIMER_HI;
        repeat (3) nextCycle();
        sampleWait();
        timerVal = mtimeAfter({hiWord, 32'hFFFF_FFFF}, 3);
        checkWord(testName, timerVal[63:32], readData);
        nextCycle();

        testName = "compare registers";
        word = randomBits(32);
        hiWord = randomBits(32);
        writeWord(PHY_ADDR_TIMER_CMP_LOW, word);
        writeWord(PHY_ADDR_TIMER_CMP_HI, hiWord);
        readAddr = PHY_ADDR_TIMER_CMP_LOW;
        sampleWait();
        checkWord(testName, word, readData);
        nextCycle();
        readAddr = PHY_ADDR_TIMER_CMP_HI;
        sampleWait();
        checkWord(testName, hiWord, readData);
        nextCycle();

        testName = "timer interrupt";
        target = mtimeModel + 64'(IRQ_LEAD);
        writeWord(PHY_ADDR_TIMER_CMP_HI, target[63:32]);
        writeWord(PHY_ADDR_TIMER_CMP_LOW, target[31:0]);
        sawLow  = 1'b0;
        sawHigh = 1'b0;
        for (int k = 0; k < 2 * IRQ_LEAD; k++) begin
            sampleWait();
            if (timerIrq === 1'b0) begin
                sawLow = 1'b1;
            end
            if (timerIrq === 1'b1 && sawLow) begin
                sawHigh = 1'b1;
            end
            nextCycle();
        end
        if (!(sawLow && sawHigh)) begin
            abortRun("timer interrupt did not rise when mtime reached mtimecmp");
        end

        testName = "serial order";
        for (int i = 0; i < SERIAL_COUNT; i++) begin
            waitSerialIdle();
            word = randomBits(32);
            expectQueue.push_back(word[7:0]);
            writeWord(PHY_ADDR_SERIAL_OUTPUT, word);
        end
        waitSerialIdle();
        checkAllReceived();

        testName = "serial back-pressure";
        accepted = 0;
        readAddr = PHY_ADDR_SERIAL_STATUS;
        for (int i = 0; i < BURST_COUNT; i++) begin
            word = randomBits(32);
            writeReq.addr = PHY_ADDR_SERIAL_OUTPUT;
            writeReq.data = word;
            writeReq.we   = 1'b1;
            sampleWait();
            // Status read in the same cycle as the write
            if (fifoAccepts(readData)) begin
                expectQueue.push_back(word[7:0]);
                accepted++;
            end
            nextCycle();
        end
        writeReq.we = 1'b0;
        if (accepted == BURST_COUNT) begin
            abortRun("FIFO never reported full during the back-to-back burst");
        end
        waitSerialIdle();
        checkAllReceived();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/ioTypes.sv
design/ioUnit.sv
design/serialFifo.sv
design/baudTimer.sv
design/uartTx.sv
design/ioSubsystem.sv
tb/ioSubsystemTb.sv
